// ==== include/pwr_seq_settings.svh ====
// Power sequencer settings
// Rail count, settle and wait limits, identity bytes
`ifndef PWR_SEQ_SETTINGS_SVH
`define PWR_SEQ_SETTINGS_SVH

// Number of sequenced rails
`define PWR_SEQ_N_RAILS 15

// Settle delay after power-good, in clk_in cycles
`define PWR_SEQ_DELAY_CYCLES 65536

// Longest wait for power-good after an enable
`define PWR_SEQ_WAIT_CYCLES 8388608

// Identity bytes, vendor ID spells "RCS "
`define PWR_SEQ_FPGA_VERSION 8'h06
`define PWR_SEQ_VENDOR_ID0 8'h52
`define PWR_SEQ_VENDOR_ID1 8'h43
`define PWR_SEQ_VENDOR_ID2 8'h53
`define PWR_SEQ_VENDOR_ID3 8'h20

`endif

// ==== logic/fault_monitor.sv ====
// Fault monitor
// Flags a rail that is slow to report power-good or loses it after
// sequencing, latches the fault and records the rails that disagreed
`timescale 1ns/1ps
`include "pwr_seq_settings.svh"

module fault_monitor import pwr_seq_pkg::*; #(
	parameter int WAIT_CYCLES = `PWR_SEQ_WAIT_CYCLES
) (
	input  logic      clk_in,
	input  logic      arst_n,
	input  logic      sysen_sync,
	input  logic      clr_err,
	input  rail_vec_t en,
	input  rail_vec_t pg_sync,
	input  rail_vec_t delay_done,
	output logic      wait_err,
	output logic      operation_err,
	output logic      err_found,
	output rail_vec_t fail_detail
);
	localparam int WW = $clog2(WAIT_CYCLES + 1);

	logic [WW-1:0] w_count;
	logic          waiting;
	logic          pg_lost;
	logic          err_found_d;

	// Any enabled rail still missing power-good
	assign waiting = sysen_sync & ~err_found & (|(en & ~pg_sync));
	// A sequenced rail has dropped out
	assign pg_lost = |(delay_done & ~pg_sync);

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			w_count       <= '0;
			wait_err      <= 1'b0;
			operation_err <= 1'b0;
			err_found     <= 1'b0;
			err_found_d   <= 1'b0;
			fail_detail   <= '0;
		end else if (clr_err) begin
			w_count       <= '0;
			wait_err      <= 1'b0;
			operation_err <= 1'b0;
			err_found     <= 1'b0;
			err_found_d   <= 1'b0;
			fail_detail   <= '0;
		end else begin
			err_found_d <= err_found;
			if (waiting) begin
				if (w_count == WW'(WAIT_CYCLES - 1)) begin
					w_count  <= '0;
					wait_err <= 1'b1;
				end else begin
					w_count <= w_count + 1'b1;
				end
			end else begin
				w_count <= '0;
			end
			if (pg_lost) begin
				operation_err <= 1'b1;
			end
			if (wait_err || operation_err) begin
				err_found <= 1'b1;
			end
			// Enables are still intact on the first fault cycle
			if (err_found && !err_found_d) begin
				fail_detail <= en ^ pg_sync;
			end
		end
	end

endmodule

// ==== logic/pwr_seq_pkg.sv ====
// Power sequencer types
// Rail vector and register port types shared by every block
`include "pwr_seq_settings.svh"

package pwr_seq_pkg;

	// Bit 0 is ATX, bit 14 is the second CPU's memory rail
	typedef logic [`PWR_SEQ_N_RAILS-1:0] rail_vec_t;

	typedef logic [7:0] reg_data_t;

	typedef enum logic [7:0] {
		VERSION = 8'h00,
		CLR_ERR = 8'h03,
		STATUS  = 8'h07,
		EN_LO   = 8'h08,
		EN_HI   = 8'h09,
		PG_LO   = 8'h0A,
		PG_HI   = 8'h0B,
		VID0    = 8'h0C,
		VID1    = 8'h0D,
		VID2    = 8'h0E,
		VID3    = 8'h0F,
		FAIL_LO = 8'h18,
		FAIL_HI = 8'h19
	} reg_addr_e;

endpackage

// ==== logic/pwr_seq_top.sv ====
// Power sequencer top level
// Board controller rail sequencing for a dual-socket server
`timescale 1ns/1ps

module pwr_seq_top import pwr_seq_pkg::*; #(
	parameter int DELAY_CYCLES = `PWR_SEQ_DELAY_CYCLES,
	parameter int WAIT_CYCLES  = `PWR_SEQ_WAIT_CYCLES
) (
	input  logic      clk_in,
	input  logic      arst_n,
	input  logic      sysen,
	input  logic      debug_in,
	input  logic      cpub_present_n,
	input  logic      bmc_boot_complete_n,
	input  rail_vec_t pg_raw,
	input  logic      rd,
	input  reg_addr_e rd_addr,
	input  logic      wr,
	input  reg_addr_e wr_addr,
	output reg_data_t rd_data,
	output logic      rd_valid,
	output logic      atx_en_n,
	output logic      miscio_en,
	output logic      vdna_en,
	output logic      vdnb_en,
	output logic      avdd_en,
	output logic      vioa_en,
	output logic      viob_en,
	output logic      vdda_en,
	output logic      vddb_en,
	output logic      vcsa_en,
	output logic      vcsb_en,
	output logic      vppab_en,
	output logic      vppcd_en,
	output logic      vddrab_en,
	output logic      vttab_en,
	output logic      vddrcd_en,
	output logic      vttcd_en,
	output logic      sysgood,
	output logic      cpub_clk_oea,
	output logic      cpub_clk_oeb
);
	logic      sysen_sync;
	rail_vec_t pg_sync;
	rail_vec_t en;
	rail_vec_t delay_done;
	logic      wait_err;
	logic      operation_err;
	logic      err_found;
	rail_vec_t fail_detail;
	logic      clr_err;

	rail_input_cond i_input_cond (
		.clk_in, .arst_n, .sysen, .debug_in, .cpub_present_n,
		.pg_raw, .en, .sysen_sync, .pg_sync
	);

	rail_sequencer #(.DELAY_CYCLES(DELAY_CYCLES)) i_sequencer (
		.clk_in, .arst_n, .sysen_sync, .err_found, .pg_sync,
		.en, .delay_done
	);

	fault_monitor #(.WAIT_CYCLES(WAIT_CYCLES)) i_fault_monitor (
		.clk_in, .arst_n, .sysen_sync, .clr_err, .en, .pg_sync, .delay_done,
		.wait_err, .operation_err, .err_found, .fail_detail
	);

	rail_output_map i_output_map (
		.clk_in, .arst_n, .cpub_present_n, .bmc_boot_complete_n, .en, .delay_done,
		.atx_en_n, .miscio_en, .vdna_en, .vdnb_en, .avdd_en, .vioa_en, .viob_en,
		.vdda_en, .vddb_en, .vcsa_en, .vcsb_en, .vppab_en, .vppcd_en,
		.vddrab_en, .vttab_en, .vddrcd_en, .vttcd_en,
		.sysgood, .cpub_clk_oea, .cpub_clk_oeb
	);

	status_regs i_status_regs (
		.clk_in, .arst_n, .rd, .rd_addr, .wr, .wr_addr,
		.cpub_present_n, .sysen_sync, .wait_err, .operation_err, .err_found,
		.sysgood, .en, .pg_sync, .fail_detail,
		.rd_data, .rd_valid, .clr_err
	);

endmodule

// ==== logic/rail_input_cond.sv ====
// Rail input conditioning
// Debug override of the system enable, power-good fill for an absent
// second CPU, and two-flop synchronizers into clk_in
`timescale 1ns/1ps
`include "pwr_seq_settings.svh"

module rail_input_cond import pwr_seq_pkg::*; (
	input  logic      clk_in,
	input  logic      arst_n,
	input  logic      sysen,
	input  logic      debug_in,
	input  logic      cpub_present_n,
	input  rail_vec_t pg_raw,
	input  rail_vec_t en,
	output logic      sysen_sync,
	output rail_vec_t pg_sync
);
	// Rails 3, 6, 8, 10, 12 and 14 belong to the second CPU
	localparam rail_vec_t CPUB_RAILS = rail_vec_t'(16'h5548);

	logic      sysen_cond;
	rail_vec_t pg_cond;
	logic      sysen_s1;
	rail_vec_t pg_s1;

	// Pulling debug_in low powers the board without the BMC
	assign sysen_cond = sysen | ~debug_in;

	always_comb begin
		for (int i = 0; i < `PWR_SEQ_N_RAILS; i++) begin
			pg_cond[i] = pg_raw[i] | (CPUB_RAILS[i] & cpub_present_n & en[i]);
		end
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			sysen_s1   <= 1'b0;
			sysen_sync <= 1'b0;
			pg_s1      <= '0;
			pg_sync    <= '0;
		end else begin
			sysen_s1   <= sysen_cond;
			sysen_sync <= sysen_s1;
			pg_s1      <= pg_cond;
			pg_sync    <= pg_s1;
		end
	end

endmodule

// ==== logic/rail_output_map.sv ====
// Rail output map
// Registers the enable vector onto the board enable pins, gates the
// second CPU's rails on presence, drives system good and clock enables
`timescale 1ns/1ps
`include "pwr_seq_settings.svh"

module rail_output_map import pwr_seq_pkg::*; (
	input  logic      clk_in,
	input  logic      arst_n,
	input  logic      cpub_present_n,
	input  logic      bmc_boot_complete_n,
	input  rail_vec_t en,
	input  rail_vec_t delay_done,
	output logic      atx_en_n,
	output logic      miscio_en,
	output logic      vdna_en,
	output logic      vdnb_en,
	output logic      avdd_en,
	output logic      vioa_en,
	output logic      viob_en,
	output logic      vdda_en,
	output logic      vddb_en,
	output logic      vcsa_en,
	output logic      vcsb_en,
	output logic      vppab_en,
	output logic      vppcd_en,
	output logic      vddrab_en,
	output logic      vttab_en,
	output logic      vddrcd_en,
	output logic      vttcd_en,
	output logic      sysgood,
	output logic      cpub_clk_oea,
	output logic      cpub_clk_oeb
);
	logic cpub_on;

	assign cpub_on = ~cpub_present_n;

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			atx_en_n     <= 1'b1;
			miscio_en    <= 1'b0;
			vdna_en      <= 1'b0;
			vdnb_en      <= 1'b0;
			avdd_en      <= 1'b0;
			vioa_en      <= 1'b0;
			viob_en      <= 1'b0;
			vdda_en      <= 1'b0;
			vddb_en      <= 1'b0;
			vcsa_en      <= 1'b0;
			vcsb_en      <= 1'b0;
			vppab_en     <= 1'b0;
			vppcd_en     <= 1'b0;
			vddrab_en    <= 1'b0;
			vttab_en     <= 1'b0;
			vddrcd_en    <= 1'b0;
			vttcd_en     <= 1'b0;
			sysgood      <= 1'b0;
			cpub_clk_oea <= 1'b0;
			cpub_clk_oeb <= 1'b0;
		end else begin
			// ATX supply enable is active low
			atx_en_n  <= ~en[0];
			miscio_en <= en[1];
			vdna_en   <= en[2];
			vdnb_en   <= en[3] & cpub_on;
			avdd_en   <= en[4];
			vioa_en   <= en[5];
			viob_en   <= en[6] & cpub_on;
			vdda_en   <= en[7];
			vddb_en   <= en[8] & cpub_on;
			vcsa_en   <= en[9];
			vcsb_en   <= en[10] & cpub_on;
			vppab_en  <= en[11];
			vppcd_en  <= en[12] & cpub_on;
			// Memory rails drive VDDR and VTT together
			vddrab_en <= en[13];
			vttab_en  <= en[13];
			vddrcd_en <= en[14] & cpub_on;
			vttcd_en  <= en[14] & cpub_on;
			sysgood   <= delay_done[`PWR_SEQ_N_RAILS-1] & ~bmc_boot_complete_n;
			cpub_clk_oea <= cpub_on;
			cpub_clk_oeb <= cpub_on;
		end
	end

endmodule

// ==== logic/rail_sequencer.sv ====
// Rail sequencer
// Chains the rail enables in order on power-up and in reverse order on
// power-down, with one shared settle counter after each power-good
`timescale 1ns/1ps
`include "pwr_seq_settings.svh"

module rail_sequencer import pwr_seq_pkg::*; #(
	parameter int DELAY_CYCLES = `PWR_SEQ_DELAY_CYCLES
) (
	input  logic      clk_in,
	input  logic      arst_n,
	input  logic      sysen_sync,
	input  logic      err_found,
	input  rail_vec_t pg_sync,
	output rail_vec_t en,
	output rail_vec_t delay_done
);
	localparam int N  = `PWR_SEQ_N_RAILS;
	localparam int CW = $clog2(DELAY_CYCLES + 1);

	logic [CW-1:0] d_count;
	rail_vec_t     settling;
	rail_vec_t     en_next;
	logic [3:0]    settle_idx;
	logic          settle_any;

	// Rails that are up but still in their settle delay
	assign settling   = en & pg_sync & ~delay_done;
	assign settle_any = |settling;

	// Lowest settling rail owns the counter
	always_comb begin
		settle_idx = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (settling[i]) begin
				settle_idx = 4'(i);
			end
		end
	end

	// A rail stays on while its successor still has power-good
	always_comb begin
		en_next[0] = sysen_sync | pg_sync[1];
		for (int k = 1; k < N - 1; k++) begin
			en_next[k] = (sysen_sync & delay_done[k-1]) | pg_sync[k+1];
		end
		en_next[N-1] = sysen_sync & delay_done[N-2];
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			en <= '0;
		end else begin
			en <= err_found ? '0 : en_next;
		end
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			d_count    <= '0;
			delay_done <= '0;
		end else if (!sysen_sync || err_found) begin
			d_count    <= '0;
			delay_done <= '0;
		end else if (settle_any) begin
			if (d_count == CW'(DELAY_CYCLES - 1)) begin
				d_count                <= '0;
				delay_done[settle_idx] <= 1'b1;
			end else begin
				d_count <= d_count + 1'b1;
			end
		end else begin
			d_count <= '0;
		end
	end

endmodule

// ==== logic/status_regs.sv ====
// Status register port
// Byte-wide read port over the sequencer state with a one-cycle read
// latency, and a write strobe that clears a latched fault
`timescale 1ns/1ps
`include "pwr_seq_settings.svh"

module status_regs import pwr_seq_pkg::*; (
	input  logic      clk_in,
	input  logic      arst_n,
	input  logic      rd,
	input  reg_addr_e rd_addr,
	input  logic      wr,
	input  reg_addr_e wr_addr,
	input  logic      cpub_present_n,
	input  logic      sysen_sync,
	input  logic      wait_err,
	input  logic      operation_err,
	input  logic      err_found,
	input  logic      sysgood,
	input  rail_vec_t en,
	input  rail_vec_t pg_sync,
	input  rail_vec_t fail_detail,
	output reg_data_t rd_data,
	output logic      rd_valid,
	output logic      clr_err
);
	reg_data_t status_byte;

	assign status_byte = {2'b00, ~cpub_present_n, wait_err, operation_err,
		err_found, sysen_sync, sysgood};

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid <= 1'b0;
			clr_err  <= 1'b0;
		end else begin
			rd_valid <= rd;
			clr_err  <= wr && (wr_addr == CLR_ERR);
		end
	end

	// Read data only moves on a strobe
	always_ff @(posedge clk_in) begin
		if (rd) begin
			case (rd_addr)
				VERSION: rd_data <= `PWR_SEQ_FPGA_VERSION;
				CLR_ERR: rd_data <= 8'hFF;
				STATUS:  rd_data <= status_byte;
				EN_LO:   rd_data <= en[7:0];
				EN_HI:   rd_data <= {1'b0, en[14:8]};
				PG_LO:   rd_data <= pg_sync[7:0];
				PG_HI:   rd_data <= {1'b0, pg_sync[14:8]};
				VID0:    rd_data <= `PWR_SEQ_VENDOR_ID0;
				VID1:    rd_data <= `PWR_SEQ_VENDOR_ID1;
				VID2:    rd_data <= `PWR_SEQ_VENDOR_ID2;
				VID3:    rd_data <= `PWR_SEQ_VENDOR_ID3;
				FAIL_LO: rd_data <= fail_detail[7:0];
				FAIL_HI: rd_data <= {1'b0, fail_detail[14:8]};
				default: rd_data <= 8'h00;
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the power sequencer testbench under Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module tb_pwr_seq -o tb_pwr_seq
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_pwr_seq > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
exit 0

// ==== src.f ====
+incdir+include
logic/pwr_seq_pkg.sv
logic/rail_input_cond.sv
logic/rail_sequencer.sv
logic/fault_monitor.sv
logic/rail_output_map.sv
logic/status_regs.sv
logic/pwr_seq_top.sv
tests/tb_pwr_seq.sv

// ==== tests/tb_pwr_seq.sv ====
// Power sequencer testbench
// Runs a table of board scenarios against the top level, with a rail
// model that answers each enable pin with power-good
`timescale 1ns/1ps

module tb_pwr_seq import pwr_seq_pkg::*; ();
	localparam int DELAY    = 8;
	localparam int WAIT     = 64;
	localparam int N        = 15;
	localparam int N_ROWS   = 5;
	localparam int NONE     = 31;
	localparam int PG_DELAY = 5;
	localparam int SEED     = 6844;
	localparam int LIMIT    = (N_ROWS + 1) * (N * (DELAY + 10) + WAIT + 100);
	// Rails 3, 6, 8, 10, 12 and 14 belong to the second CPU
	localparam rail_vec_t CPUB_RAILS = 15'h5548;

	logic      clk_in = 1'b0;
	logic      arst_n, sysen, debug_in, cpub_present_n, bmc_boot_complete_n;
	rail_vec_t pg_raw;
	logic      rd, wr, rd_valid;
	reg_addr_e rd_addr, wr_addr;
	reg_data_t rd_data;
	logic      atx_en_n, miscio_en, vdna_en, vdnb_en, avdd_en, vioa_en, viob_en;
	logic      vdda_en, vddb_en, vcsa_en, vcsb_en, vppab_en, vppcd_en;
	logic      vddrab_en, vttab_en, vddrcd_en, vttcd_en;
	logic      sysgood, cpub_clk_oea, cpub_clk_oeb;

	int        cycle = 0;
	int        errors = 0;
	int        checks = 0;
	int        stuck_rail = NONE;
	int        drop_rail = NONE;
	int        row_start = 0;
	int        pg_age [N];
	int        rise_cycle [N];
	rail_vec_t model_pins;

	// Scenario table, one entry per row in each column
	string       tab_name [N_ROWS];
	logic        tab_cpub_n [N_ROWS];
	int          tab_stuck [N_ROWS];
	int          tab_drop [N_ROWS];
	logic        tab_clear [N_ROWS];
	reg_data_t   tab_status [N_ROWS];
	logic [15:0] tab_en [N_ROWS];
	logic [15:0] tab_fail [N_ROWS];

	pwr_seq_top #(.DELAY_CYCLES(DELAY), .WAIT_CYCLES(WAIT)) i_dut (.*);

	always #2 clk_in = ~clk_in;

	always @(posedge clk_in) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// Enable pins folded back onto rail indices
	function automatic rail_vec_t rail_pins();
		return {vddrcd_en & vttcd_en, vddrab_en & vttab_en, vppcd_en, vppab_en,
			vcsb_en, vcsa_en, vddb_en, vdda_en, viob_en, vioa_en, avdd_en,
			vdnb_en, vdna_en, miscio_en, ~atx_en_n};
	endfunction

	// Rail model, power-good follows an enable pin after PG_DELAY cycles
	initial begin
		pg_raw = '0;
		for (int i = 0; i < N; i++) begin
			pg_age[i] = 0;
			rise_cycle[i] = 0;
		end
		forever begin
			@(posedge clk_in);
			#1;
			model_pins = rail_pins();
			for (int i = 0; i < N; i++) begin
				if (!model_pins[i]) begin
					pg_age[i] = 0;
				end else if (pg_age[i] < 255) begin
					if (pg_age[i] == 0) begin
						rise_cycle[i] = cycle;
					end
					pg_age[i] = pg_age[i] + 1;
				end
				pg_raw[i] = (pg_age[i] >= PG_DELAY) && (i != stuck_rail) && (i != drop_rail);
			end
		end
	end

	task automatic next_cycle();
		@(posedge clk_in);
		#1;
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("Failure at %0t ns: %s", $time, msg);
	endtask

	task automatic write_reg(input reg_addr_e addr);
		wr = 1'b1;
		wr_addr = addr;
		next_cycle();
		wr = 1'b0;
	endtask

	task automatic read_reg(input reg_addr_e addr, output reg_data_t data);
		int hold;
		hold = $urandom_range(3, 0);
		repeat (hold) next_cycle();
		rd = 1'b1;
		rd_addr = addr;
		next_cycle();
		rd = 1'b0;
		// Read data comes back one cycle after the strobe
		if (!rd_valid) begin
			note_failure($sformatf("rd_valid did not follow the read of 0x%h by one cycle",
				addr));
		end
		data = rd_data;
	endtask

	// Low and high register halves joined into one rail vector
	task automatic read_rails(input reg_addr_e lo, input reg_addr_e hi,
		output logic [15:0] value);
		reg_data_t lo_byte;
		reg_data_t hi_byte;
		read_reg(lo, lo_byte);
		read_reg(hi, hi_byte);
		value = {hi_byte, lo_byte};
	endtask

	task automatic set_row(input int r, input string name, input logic cpub_n,
		input int stuck, input int drop, input logic clear, input reg_data_t status,
		input logic [15:0] en, input logic [15:0] fail);
		tab_name[r] = name;
		tab_cpub_n[r] = cpub_n;
		tab_stuck[r] = stuck;
		tab_drop[r] = drop;
		tab_clear[r] = clear;
		tab_status[r] = status;
		tab_en[r] = en;
		tab_fail[r] = fail;
	endtask

	task automatic power_down();
		stuck_rail = NONE;
		drop_rail = NONE;
		sysen = 1'b0;
		repeat (4) next_cycle();
		write_reg(CLR_ERR);
		while (rail_pins() != '0) next_cycle();
		// Let power-good drain through the synchronizers
		repeat (6) next_cycle();
	endtask

	// Ends on sysgood, or when a fault drops the ATX enable again
	task automatic wait_for_sequence();
		while (atx_en_n) next_cycle();
		while (!sysgood && !atx_en_n) next_cycle();
	endtask

	task automatic run_row(input int r);
		reg_data_t   status;
		logic [15:0] value;
		rail_vec_t   exp_pins;
		logic        fault;
		int          prev;
		fault = (tab_stuck[r] != NONE) || (tab_drop[r] != NONE);
		exp_pins = tab_cpub_n[r] ? ~CPUB_RAILS : '1;
		power_down();
		cpub_present_n = tab_cpub_n[r];
		stuck_rail = tab_stuck[r];
		row_start = cycle;
		sysen = 1'b1;
		wait_for_sequence();
		if (tab_drop[r] != NONE) begin
			if (!sysgood) begin
				note_failure("sysgood did not rise before the power-good drop");
			end
			drop_rail = tab_drop[r];
			while (!atx_en_n) next_cycle();
		end
		if (fault) begin
			check_value("sysgood", 16'(sysgood), 16'h0);
			check_value("enable pins", {1'b0, rail_pins()}, 16'h0);
			check_value("memory rail pins",
				16'({vddrab_en, vttab_en, vddrcd_en, vttcd_en}), 16'h0);
		end else begin
			if (!sysgood) begin
				note_failure("enables dropped before sysgood rose");
			end
			check_value("enable pins", {1'b0, rail_pins()}, {1'b0, exp_pins});
			check_value("cpub_clk_oea/oeb", 16'({cpub_clk_oea, cpub_clk_oeb}),
				tab_cpub_n[r] ? 16'h0 : 16'h3);
			check_value("memory rail pins",
				16'({vddrab_en, vttab_en, vddrcd_en, vttcd_en}),
				16'({exp_pins[13], exp_pins[13], exp_pins[14], exp_pins[14]}));
			prev = row_start;
			for (int i = 0; i < N; i++) begin
				if (exp_pins[i]) begin
					check_value($sformatf("rail %0d rise order", i),
						16'(rise_cycle[i] > prev), 16'h1);
					prev = rise_cycle[i];
				end
			end
			read_rails(PG_LO, PG_HI, value);
			check_value("PG", value, 16'h7FFF);
		end
		read_reg(STATUS, status);
		check_value("STATUS", 16'(status), 16'(tab_status[r]));
		read_rails(EN_LO, EN_HI, value);
		check_value("EN", value, tab_en[r]);
		read_rails(FAIL_LO, FAIL_HI, value);
		check_value("FAIL", value, tab_fail[r]);
		if (tab_clear[r]) begin
			stuck_rail = NONE;
			write_reg(CLR_ERR);
			// The fault clears one cycle after the clr_err pulse
			next_cycle();
			read_reg(STATUS, status);
			check_value("STATUS[4:2] after clear", 16'(status[4:2]), 16'h0);
			wait_for_sequence();
			if (!sysgood) begin
				note_failure("sequence did not complete after the fault was cleared");
			end
			read_reg(STATUS, status);
			check_value("STATUS after restart", 16'(status), 16'h0023);
		end
	endtask

	initial begin
		int        errors_before;
		reg_data_t data;
		void'($urandom(SEED));
		arst_n = 1'b0;
		sysen = 1'b0;
		debug_in = 1'b1;
		cpub_present_n = 1'b0;
		bmc_boot_complete_n = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		rd_addr = VERSION;
		wr_addr = VERSION;
		//       row name            cpub_n stuck drop  clear STATUS  EN        FAIL
		set_row(0, "full power-up", 1'b0, NONE, NONE, 1'b0, 8'h23, 16'h7FFF, 16'h0000);
		set_row(1, "second CPU absent", 1'b1, NONE, NONE, 1'b0, 8'h03, 16'h7FFF, 16'h0000);
		set_row(2, "stuck rail 5", 1'b0, 5, NONE, 1'b0, 8'h36, 16'h0000, 16'h0020);
		set_row(3, "power loss rail 9", 1'b0, NONE, 9, 1'b0, 8'h2E, 16'h0000, 16'h0200);
		set_row(4, "clear and restart", 1'b0, 11, NONE, 1'b1, 8'h36, 16'h0000, 16'h0800);
		repeat (4) @(posedge clk_in);
		#1;
		arst_n = 1'b1;
		check_value("atx_en_n after reset", 16'(atx_en_n), 16'h1);
		check_value("sysgood after reset", 16'(sysgood), 16'h0);
		for (int r = 0; r < N_ROWS; r++) begin
			errors_before = errors;
			run_row(r);
			$display("Test %0d %s: %0d errors", r + 1, tab_name[r], errors - errors_before);
		end
		errors_before = errors;
		read_reg(VERSION, data);
		check_value("VERSION", 16'(data), 16'h0006);
		read_reg(VID0, data);
		check_value("VID0", 16'(data), 16'h0052);
		read_reg(VID1, data);
		check_value("VID1", 16'(data), 16'h0043);
		read_reg(VID2, data);
		check_value("VID2", 16'(data), 16'h0053);
		read_reg(VID3, data);
		check_value("VID3", 16'(data), 16'h0020);
		read_reg(CLR_ERR, data);
		check_value("CLR_ERR", 16'(data), 16'h00FF);
		read_reg(reg_addr_e'(8'h05), data);
		check_value("unmapped 0x05", 16'(data), 16'h0000);
		$display("Test %0d identity registers: %0d errors", N_ROWS + 1, errors - errors_before);
		$display("Tests run: %0d, checks: %0d, errors: %0d", N_ROWS + 1, checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
